/* hdl/source_pkg.sv */
// shared widths and bus structs for the biased load streamer, referenced by scoped names
`default_nettype none

package source_pkg;

  localparam int unsigned ADDR_W  = 32;            // byte address
  localparam int unsigned STRM_DW = 32;            // output stream word
  localparam int unsigned MEM_DW  = STRM_DW + 32;  // extra word for misaligned reads
  localparam int unsigned CNT_W   = 16;            // lengths and counters
  localparam int unsigned OFS_W   = 2;             // byte offset inside a word

  // address pattern, sampled by the generator on start
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;  // first byte address
    logic [CNT_W-1:0]  tot_len;    // total number of words
    logic [CNT_W-1:0]  d0_len;     // inner loop length
    logic [CNT_W-1:0]  d0_stride;  // inner step in bytes
    logic [ADDR_W-1:0] d1_stride;  // outer step, may span the whole memory
  } addr_cfg_t;

  // control plane input
  typedef struct packed {
    logic      req_start;    // start if ready_start
    logic      ignore_bias;  // skip the bias stream
    addr_cfg_t cfg;
  } source_ctrl_t;

  // status back to the host
  typedef struct packed {
    logic ready_start;  // idle, start accepted
    logic done;         // one cycle at end of transfer
    logic gen_done;     // all addresses generated
  } source_flags_t;

  // memory request side
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;  // word aligned
  } mem_req_t;

  // memory response side
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [MEM_DW-1:0] r_data;
  } mem_rsp_t;

  // valid and data of a stream, ready travels alone
  typedef struct packed {
    logic               valid;
    logic [STRM_DW-1:0] data;
  } stream_t;

endpackage

`default_nettype wire

/* hdl/stream_fifo.sv */
// valid/ready FIFO of WIDTH-bit words, ports carry {valid, data} as one vector
`default_nettype none

module stream_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 2
) (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  wire logic           clear_i,       // flush all entries
  input  wire logic [WIDTH:0] push_i,        // {valid, data}
  output logic                push_ready_o,
  output logic      [WIDTH:0] pop_o,         // {valid, data}
  input  wire logic           pop_ready_i,
  output logic                empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_B = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];  // storage, no reset
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_B-1:0] cnt_q;
  logic             push, pop;

  assign push_ready_o = (cnt_q != CNT_B'(DEPTH));       // not full
  assign empty_o      = (cnt_q == '0);
  assign pop_o        = {~empty_o, mem_q[rd_ptr_q]};    // registered, no fall-through
  assign push         = push_i[WIDTH] & push_ready_o;
  assign pop          = ~empty_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // wrap
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)      cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !clear_i) mem_q[wr_ptr_q] <= push_i[WIDTH-1:0];
  end

  // upstream logic must respect push_ready_o
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i[WIDTH] |-> push_ready_o);

endmodule

`default_nettype wire

/* hdl/addr_gen.sv */
// two-level strided address generator, adds one bias word per address and feeds the address queue
`default_nettype none

module addr_gen (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   clear_i,
  input  wire logic                   enable_i,
  input  wire logic                   start_i,        // sample cfg, restart counters
  input  wire source_pkg::addr_cfg_t  cfg_i,
  input  wire logic                   ignore_bias_i,
  input  wire source_pkg::stream_t    bias_i,
  output logic                        bias_ready_o,
  output source_pkg::stream_t         addr_o,
  input  wire logic                   addr_ready_i,
  output logic                        done_o
);

  localparam int unsigned AW = source_pkg::ADDR_W;
  localparam int unsigned CW = source_pkg::CNT_W;
  localparam int unsigned DW = source_pkg::STRM_DW;

  source_pkg::addr_cfg_t cfg_q;        // sampled pattern
  logic                  running_q;
  logic                  done_q;
  logic                  ign_q;        // sampled ignore_bias
  logic [CW-1:0]         d0_idx_q;     // inner index
  logic [CW-1:0]         tot_idx_q;    // addresses issued so far
  logic [AW-1:0]         d0_ofs_q;     // inner index * d0_stride
  logic [AW-1:0]         d1_ofs_q;     // outer index * d1_stride
  logic [AW-1:0]         bias_ofs;
  logic                  step, last_addr, last_d0;

  assign step      = enable_i & running_q & addr_ready_i & (ign_q | bias_i.valid);
  assign last_addr = (tot_idx_q == cfg_q.tot_len - 1'b1);
  assign last_d0   = (d0_idx_q == cfg_q.d0_len - 1'b1);
  assign bias_ofs  = ign_q ? '0 : AW'(bias_i.data);

  assign bias_ready_o = enable_i & running_q & addr_ready_i & ~ign_q;  // bias taken with its address
  assign addr_o.valid = step;
  assign addr_o.data  = DW'(cfg_q.base_addr + d0_ofs_q + d1_ofs_q + bias_ofs);
  assign done_o       = done_q | (step & last_addr);  // high in the cycle of the last push

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      ign_q     <= 1'b0;
      d0_idx_q  <= '0;
      tot_idx_q <= '0;
      d0_ofs_q  <= '0;
      d1_ofs_q  <= '0;
    end else if (clear_i) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
    end else if (start_i) begin
      running_q <= (cfg_i.tot_len != '0);  // empty transfer finishes at once
      done_q    <= (cfg_i.tot_len == '0);
      ign_q     <= ignore_bias_i;
      d0_idx_q  <= '0;
      tot_idx_q <= '0;
      d0_ofs_q  <= '0;
      d1_ofs_q  <= '0;
    end else if (step) begin
      tot_idx_q <= tot_idx_q + 1'b1;
      if (last_addr) begin
        running_q <= 1'b0;
        done_q    <= 1'b1;
      end
      if (last_d0) begin  // next outer row
        d0_idx_q <= '0;
        d0_ofs_q <= '0;
        d1_ofs_q <= d1_ofs_q + cfg_q.d1_stride;
      end else begin
        d0_idx_q <= d0_idx_q + 1'b1;
        d0_ofs_q <= d0_ofs_q + AW'(cfg_q.d0_stride);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) cfg_q <= cfg_i;  // held for the whole transfer
  end

endmodule

`default_nettype wire

/* hdl/load_realign.sv */
// holds memory responses and shifts them by the queued byte offset to form the output stream
`default_nettype none

module load_realign #(
  parameter int unsigned OFS_DEPTH = 8
) (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic                             clear_i,
  input  wire logic                             enable_i,
  input  wire logic [source_pkg::OFS_W:0]       grant_ofs_i,   // {granted, byte offset}
  input  wire source_pkg::mem_rsp_t             rsp_i,
  output source_pkg::stream_t                   strm_o,
  input  wire logic                             strm_ready_i
);

  localparam int unsigned OW = source_pkg::OFS_W;
  localparam int unsigned MW = source_pkg::MEM_DW;
  localparam int unsigned DW = source_pkg::STRM_DW;

  logic          hold_valid_q;         // response waiting for ready
  logic [MW-1:0] hold_data_q;
  logic [MW-1:0] word;
  logic [MW-1:0] realigned;
  logic [OW:0]   ofs_pop;              // {valid, offset}
  logic          beat;

  assign word      = rsp_i.r_valid ? rsp_i.r_data : hold_data_q;  // live word wins
  assign realigned = word >> {ofs_pop[OW-1:0], 3'b000};           // offset in bytes

  assign strm_o.valid = enable_i & (rsp_i.r_valid | hold_valid_q);
  assign strm_o.data  = realigned[DW-1:0];
  assign beat         = strm_o.valid & strm_ready_i;

  // one offset per granted request, popped with its word
  stream_fifo #(
    .WIDTH ( OW        ),
    .DEPTH ( OFS_DEPTH )
  ) i_ofs_fifo (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .push_i       ( grant_ofs_i ),
    .push_ready_o (             ),
    .pop_o        ( ofs_pop     ),
    .pop_ready_i  ( beat        ),
    .empty_o      (             )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (enable_i) begin
      if (rsp_i.r_valid && !strm_ready_i) hold_valid_q <= 1'b1;  // park it
      else if (strm_ready_i)              hold_valid_q <= 1'b0;  // delivered
    end
  end

  always_ff @(posedge clk_i) begin
    if (enable_i && rsp_i.r_valid) hold_data_q <= rsp_i.r_data;
  end

  // every response needs the offset pushed at its grant
  a_rsp_has_ofs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.r_valid |-> ofs_pop[OW]);

endmodule

`default_nettype wire

/* hdl/source_ctrl.sv */
// streamer FSM: idle, working, drain; counts delivered words and raises the host flags
`default_nettype none

module source_ctrl (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      clear_i,
  input  wire logic                      enable_i,
  input  wire source_pkg::source_ctrl_t  ctrl_i,
  input  wire logic                      gen_done_i,    // generator finished
  input  wire logic                      addr_empty_i,  // address queue drained
  input  wire logic                      beat_i,        // stream word transferred
  output logic                           busy_o,
  output logic                           gen_start_o,
  output logic                           gen_clear_o,
  output source_pkg::source_flags_t      flags_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_WORKING, ST_DRAIN} state_e;

  state_e                          state_q, state_d;
  logic [source_pkg::CNT_W-1:0]    cnt_q;   // delivered words
  logic                            finish;

  assign finish = enable_i & (state_q == ST_DRAIN) & addr_empty_i
                & (cnt_q == ctrl_i.cfg.tot_len);

  assign busy_o      = (state_q != ST_IDLE);
  assign gen_start_o = enable_i & ~clear_i & (state_q == ST_IDLE) & ctrl_i.req_start;
  assign gen_clear_o = clear_i | finish;  // generator back to rest

  assign flags_o.ready_start = (state_q == ST_IDLE);
  assign flags_o.done        = finish;     // single cycle, state leaves drain
  assign flags_o.gen_done    = gen_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (ctrl_i.req_start) state_d = ST_WORKING;
      ST_WORKING: if (gen_done_i)       state_d = ST_DRAIN;
      ST_DRAIN:   if (finish)           state_d = ST_IDLE;
      default:                          state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)       state_q <= ST_IDLE;
    else if (clear_i)  state_q <= ST_IDLE;
    else if (enable_i) state_q <= state_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)                 cnt_q <= '0;
    else if (clear_i || finish)  cnt_q <= '0;
    else if (enable_i && beat_i) cnt_q <= cnt_q + 1'b1;
  end

  // stream words only come from requests of an active transfer
  a_beat_busy: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    beat_i |-> busy_o);

endmodule

`default_nettype wire

/* hdl/biased_source.sv */
// top of the biased load streamer: generator, address queue, memory requests, realign and FSM
`default_nettype none

module biased_source #(
  parameter int unsigned ADDR_FIFO_DEPTH = 2,
  parameter int unsigned OFS_FIFO_DEPTH  = 8   // >= outstanding granted requests
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      clear_i,
  input  wire logic                      enable_i,
  input  wire source_pkg::source_ctrl_t  ctrl_i,
  output source_pkg::source_flags_t      flags_o,
  input  wire source_pkg::stream_t       bias_i,
  output logic                           bias_ready_o,
  output source_pkg::mem_req_t           mem_req_o,
  output logic                           mem_r_ready_o,
  input  wire source_pkg::mem_rsp_t      mem_rsp_i,
  output source_pkg::stream_t            strm_o,
  input  wire logic                      strm_ready_i
);

  localparam int unsigned AW = source_pkg::ADDR_W;
  localparam int unsigned OW = source_pkg::OFS_W;
  localparam int unsigned DW = source_pkg::STRM_DW;

  source_pkg::stream_t addr_push, addr_pop;
  logic                addr_push_ready;
  logic                addr_empty;
  logic                busy, gen_start, gen_clear, gen_done;
  logic                req, grant;
  logic [OW:0]         grant_ofs;   // {granted, byte offset}

  addr_gen i_addr_gen (
    .clk_i         ( clk_i              ),
    .rst_ni        ( rst_ni             ),
    .clear_i       ( gen_clear          ),
    .enable_i      ( enable_i           ),
    .start_i       ( gen_start          ),
    .cfg_i         ( ctrl_i.cfg         ),
    .ignore_bias_i ( ctrl_i.ignore_bias ),
    .bias_i        ( bias_i             ),
    .bias_ready_o  ( bias_ready_o       ),
    .addr_o        ( addr_push          ),
    .addr_ready_i  ( addr_push_ready    ),
    .done_o        ( gen_done           )
  );

  stream_fifo #(
    .WIDTH ( DW              ),
    .DEPTH ( ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_i       ( addr_push       ),
    .push_ready_o ( addr_push_ready ),
    .pop_o        ( addr_pop        ),
    .pop_ready_i  ( grant           ),  // pop on grant
    .empty_o      ( addr_empty      )
  );

  // requests stop under back-pressure so responses have room
  assign req   = enable_i & busy & addr_pop.valid & strm_ready_i;
  assign grant = req & mem_rsp_i.gnt;

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = {addr_pop.data[AW-1:OW], {OW{1'b0}}};  // word aligned
  assign mem_r_ready_o  = strm_ready_i;
  assign grant_ofs      = {grant, addr_pop.data[OW-1:0]};         // low bits go to realign

  load_realign #(
    .OFS_DEPTH ( OFS_FIFO_DEPTH )
  ) i_load_realign (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .enable_i     ( enable_i     ),
    .grant_ofs_i  ( grant_ofs    ),
    .rsp_i        ( mem_rsp_i    ),
    .strm_o       ( strm_o       ),
    .strm_ready_i ( strm_ready_i )
  );

  source_ctrl i_source_ctrl (
    .clk_i        ( clk_i                  ),
    .rst_ni       ( rst_ni                 ),
    .clear_i      ( clear_i                ),
    .enable_i     ( enable_i               ),
    .ctrl_i       ( ctrl_i                 ),
    .gen_done_i   ( gen_done               ),
    .addr_empty_i ( addr_empty             ),
    .beat_i       ( strm_o.valid & strm_ready_i ),
    .busy_o       ( busy                   ),
    .gen_start_o  ( gen_start              ),
    .gen_clear_o  ( gen_clear              ),
    .flags_o      ( flags_o                )
  );

  // queue head must not move before its grant
  a_req_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (mem_req_o.req && !mem_rsp_i.gnt) |=> $stable(mem_req_o.addr));

endmodule

`default_nettype wire

/* dv/tb_mem_model.sv */
// memory model for the streamer testbench: random grant, in-order reads after 1 to 4 cycles
`default_nettype none

module tb_mem_model (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire source_pkg::mem_req_t  req_i,
  input  wire logic                  r_ready_i,
  output source_pkg::mem_rsp_t       rsp_o,
  output logic                       idle_o     // no read outstanding
);

  integer      seed = 59779;
  int unsigned cyc;                 // cycle count for due times
  logic [31:0] addr_q [$];          // granted word addresses, oldest first
  int unsigned due_q [$];           // cycle at which each read may return
  logic        gnt_q, rv_q, idle_q;
  logic [63:0] rdata_q;

  // byte at a is the low address byte xor 0x5a
  function automatic logic [63:0] mem_word(input logic [31:0] a);
    logic [63:0] w;
    for (int i = 0; i < 8; i++) begin
      w[8*i +: 8] = 8'(a + i) ^ 8'h5A;
    end
    return w;
  endfunction

  assign rsp_o.gnt     = gnt_q;
  assign rsp_o.r_valid = rv_q;     // stays up until r_ready takes it
  assign rsp_o.r_data  = rdata_q;
  assign idle_o        = idle_q;

  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) gnt_q <= 1'b0;
    else         gnt_q <= (($random(seed) & 3) != 0);  // grant three times in four
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc = 0;
      addr_q.delete();
      due_q.delete();
      rv_q    <= 1'b0;
      idle_q  <= 1'b1;
      rdata_q <= '0;
    end else begin
      if (rv_q && r_ready_i) begin  // head read delivered
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_i.req && gnt_q) begin
        addr_q.push_back(req_i.addr);
        due_q.push_back(cyc + 1 + ($random(seed) & 3));  // 1 to 4 cycles
      end
      cyc = cyc + 1;
      if (addr_q.size() > 0) begin
        rv_q    <= (cyc >= due_q[0]);
        rdata_q <= mem_word(addr_q[0]);
      end else begin
        rv_q    <= 1'b0;
        rdata_q <= '0;
      end
      idle_q <= (addr_q.size() == 0);
    end
  end

endmodule

`default_nettype wire

/* dv/tb_biased_source.sv */
// testbench for the biased load streamer: replays the trace, checks stream words and host flags
`default_nettype none

module tb_biased_source;

  localparam int TIMEOUT = 2000;  // cycles allowed per wait

  logic                      clk = 1'b0;
  logic                      rst_ni;
  logic                      clear, enable, strm_ready, bias_ready, r_ready, mem_idle;
  source_pkg::source_ctrl_t  ctrl;
  source_pkg::source_flags_t flags;
  source_pkg::stream_t       bias, strm;
  source_pkg::mem_req_t      mem_req;
  source_pkg::mem_rsp_t      mem_rsp;

  logic [31:0] trace_mem [0:255];
  integer      seed = 59779;
  int          ptr, errors, passed, failed;
  logic        timed_out;

  always #20 clk = ~clk;

  biased_source #(
    .ADDR_FIFO_DEPTH ( 2 ),
    .OFS_FIFO_DEPTH  ( 8 )
  ) DUT (
    .clk_i         ( clk        ),
    .rst_ni        ( rst_ni     ),
    .clear_i       ( clear      ),
    .enable_i      ( enable     ),
    .ctrl_i        ( ctrl       ),
    .flags_o       ( flags      ),
    .bias_i        ( bias       ),
    .bias_ready_o  ( bias_ready ),
    .mem_req_o     ( mem_req    ),
    .mem_r_ready_o ( r_ready    ),
    .mem_rsp_i     ( mem_rsp    ),
    .strm_o        ( strm       ),
    .strm_ready_i  ( strm_ready )
  );

  tb_mem_model i_mem (
    .clk_i     ( clk      ),
    .rst_ni    ( rst_ni   ),
    .req_i     ( mem_req  ),
    .r_ready_i ( r_ready  ),
    .rsp_o     ( mem_rsp  ),
    .idle_o    ( mem_idle )
  );

  task automatic show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("Error: %s expected 0x%08h got 0x%08h", name, exp, got);
  endtask

  // stop mid-transfer: freeze, let the memory drain, then clear
  task automatic abort_transfer();
    int cyc;
    enable     = 1'b0;
    strm_ready = 1'b1;
    cyc        = 0;
    while (!mem_idle && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!mem_idle) begin
      $display("memory model never drained before the clear");
      errors++;
      timed_out = 1'b1;
    end
    clear = 1'b1;  // no request in the clear cycle
    @(negedge clk);
    clear  = 1'b0;
    enable = 1'b1;
    #1;
    if (flags.ready_start !== 1'b1) show_mismatch("ready_start", 1, flags.ready_start);
    if (flags.gen_done !== 1'b0) show_mismatch("flags_o.gen_done", 0, flags.gen_done);
    if (strm.valid !== 1'b0) show_mismatch("strm_o.valid", 0, strm.valid);
  endtask

  // one trace entry: flags, config, bias words, expected words
  task automatic run_test(input int tnum);
    logic [31:0] fl;
    int          tot, beats, bias_idx, dones, cyc;
    logic [31:0] bias_w [$];
    logic [31:0] exp_w [$];
    logic        stall;        // word offered but not taken last cycle
    logic [31:0] stall_data;
    fl  = trace_mem[ptr];
    tot = trace_mem[ptr+2];
    ctrl.ignore_bias   = fl[0];
    ctrl.cfg.base_addr = trace_mem[ptr+1];
    ctrl.cfg.tot_len   = trace_mem[ptr+2][15:0];
    ctrl.cfg.d0_len    = trace_mem[ptr+3][15:0];
    ctrl.cfg.d0_stride = trace_mem[ptr+4][15:0];
    ctrl.cfg.d1_stride = trace_mem[ptr+5];
    ptr = ptr + 6;
    for (int i = 0; i < tot; i++) bias_w.push_back(trace_mem[ptr+i]);
    for (int i = 0; i < tot; i++) exp_w.push_back(trace_mem[ptr+tot+i]);
    ptr = ptr + 2*tot;
    cyc = 0;
    while (!flags.ready_start && cyc < TIMEOUT) begin  // idle before start
      @(negedge clk);
      cyc++;
    end
    if (!flags.ready_start) begin
      $display("test %0d: DUT never became ready to start", tnum);
      errors++;
      timed_out = 1'b1;
    end
    beats      = 0;
    bias_idx   = 0;
    dones      = 0;
    cyc        = 0;
    stall      = 1'b0;
    stall_data = '0;
    ctrl.req_start = 1'b1;  // one cycle pulse
    while (dones == 0 && !timed_out) begin
      strm_ready = fl[1] ? ($random(seed) % 2 != 0) : 1'b1;
      bias.valid = ~fl[0] & (bias_idx < tot);
      bias.data  = (bias_idx < tot) ? bias_w[bias_idx] : '0;
      #1;  // settle, handshakes below happen at the next rising edge
      if (stall && strm.valid !== 1'b1) begin  // valid must wait for ready
        show_mismatch("strm_o.valid", 1, strm.valid);
      end else if (stall && strm.data !== stall_data) begin
        show_mismatch("strm_o.data", stall_data, strm.data);
      end
      if (strm.valid && strm_ready) begin
        if (beats >= tot) begin
          $display("test %0d: stream word beyond tot_len", tnum);
          errors++;
        end else if (strm.data !== exp_w[beats]) begin
          show_mismatch("strm_o.data", exp_w[beats], strm.data);
        end
        beats++;
      end
      stall      = strm.valid && !strm_ready;
      stall_data = strm.data;
      if (bias.valid && bias_ready) bias_idx++;
      if (!fl[0] && flags.gen_done !== (bias_idx == tot)) begin  // last bias word, last address
        show_mismatch("flags_o.gen_done", (bias_idx == tot), flags.gen_done);
      end
      if (flags.done) begin
        dones++;
        if (beats != tot) show_mismatch("transfer count", tot, beats);
        if (flags.gen_done !== 1'b1) show_mismatch("flags_o.gen_done", 1, flags.gen_done);
      end
      @(negedge clk);
      ctrl.req_start = 1'b0;
      cyc++;
      if (cyc >= TIMEOUT) begin
        $display("test %0d: timed out waiting for done", tnum);
        errors++;
        timed_out = 1'b1;
      end
      if (fl[2] && beats == 3) begin
        abort_transfer();
        break;
      end
    end
    if (!fl[2] && !timed_out) begin
      #1;
      if (flags.done !== 1'b0) show_mismatch("done", 0, flags.done);  // single cycle
      if (flags.ready_start !== 1'b1) show_mismatch("ready_start", 1, flags.ready_start);
      if (flags.gen_done !== 1'b0) show_mismatch("flags_o.gen_done", 0, flags.gen_done);
    end
  endtask

  initial begin
    int n_tests;
    int err0;
    clear      = 1'b0;
    enable     = 1'b1;
    strm_ready = 1'b1;
    ctrl       = '0;
    bias       = '0;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    timed_out  = 1'b0;
    rst_ni     = 1'b0;
    $readmemh("dv/source_trace.txt", trace_mem);
    n_tests = trace_mem[0];
    ptr     = 1;
    repeat (10) @(negedge clk);
    rst_ni = 1'b1;
    #1;
    err0 = errors;
    if (flags.ready_start !== 1'b1) show_mismatch("ready_start", 1, flags.ready_start);
    if (flags.done !== 1'b0) show_mismatch("done", 0, flags.done);
    if (strm.valid !== 1'b0) show_mismatch("strm_o.valid", 0, strm.valid);
    if (mem_req.req !== 1'b0) show_mismatch("mem_req_o.req", 0, mem_req.req);
    if (bias_ready !== 1'b0) show_mismatch("bias_ready_o", 0, bias_ready);
    $display("reset state: %0s", (errors == err0) ? "ok" : "wrong");
    for (int t = 1; t <= n_tests && !timed_out; t++) begin
      err0 = errors;
      @(negedge clk);
      run_test(t);
      if (errors == err0) begin
        passed++;
        $display("test %0d passed", t);
      end else begin
        failed++;
        $display("test %0d failed with %0d errors", t, errors - err0);
      end
    end
    $display("tests passed %0d, failed %0d, total errors %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/source_trace.txt */
// header word: number of tests; per test: flags base tot_len d0_len d0_stride d1_stride,
// then tot_len bias words, then tot_len expected stream words (flags 1 ignore, 2 toggle ready, 4 clear)
5
// aligned 1-D load, bias ignored
1 00000100 4 4 4 0
0 0 0 0
59585B5A 5D5C5F5E 51505352 55545756
// two-level strided pattern
1 00000200 6 3 10 40
0 0 0 0 0 0
59585B5A 49484B4A 79787B7A 19181B1A 09080B0A 39383B3A
// misaligned bias words under back-pressure
2 00000300 4 2 8 20
1 2 3 13
5E59585B 57565150 7C7F7E79 64676661
// clear after three words
7 00000400 8 8 4 0
0 0 0 0 0 0 0 0
59585B5A 5D5C5F5E 51505352 55545756 49484B4A 4D4C4F4E 41404342 45444746
// biased load following the clear
2 00000500 3 3 4 0
2 5 E
5F5E5958 56515053 43424D4C

/* project.f */
hdl/source_pkg.sv
hdl/stream_fifo.sv
hdl/addr_gen.sv
hdl/load_realign.sv
hdl/source_ctrl.sv
hdl/biased_source.sv
dv/tb_mem_model.sv
dv/tb_biased_source.sv

/* Bender.yml */
package:
  name: biased_source

sources:
  - files:
      - hdl/source_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/addr_gen.sv
      - hdl/load_realign.sv
      - hdl/source_ctrl.sv
      - hdl/biased_source.sv
  - target: test
    files:
      - dv/tb_mem_model.sv
      - dv/tb_biased_source.sv
